/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = immu_top_tb
FILELIST = immu_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* immu_top.f */
+incdir+rtl
rtl/immu_pkg.sv
rtl/itlb_ram.sv
rtl/immu_msr.sv
rtl/immu.sv
rtl/immu_top.sv
tb/immu_top_assert.sv
tb/immu_top_tb.sv

/* rtl/immu.sv */
`timescale 1ns/1ps

`include "immu_defs.svh"

module immu (
   input  logic                clk,
   input  logic                rst_n,
   // Request
   input  logic                re,
   input  immu_pkg::vpn_t      vpn,
   // Status from MSR front end
   input  immu_pkg::psr_t      psr,
   // Registered TLB array outputs
   input  immu_pkg::word_t     tlb_lo,
   input  immu_pkg::word_t     tlb_hi,
   // Response
   output immu_pkg::immu_rsp_t rsp,
   output logic                rsp_valid
);

   import immu_pkg::*;

   localparam bit UNC_SEG = (`IMMU_UNC_SEG != 0);
   localparam int PPN_W   = $bits(ppn_t);

   // Request stage
   vpn_t     vpn_q;
   psr_t     psr_q;
   // Set once the first request has been taken
   logic     req_seen;

   // Decoded entry
   itlb_lo_t ent_lo;
   itlb_hi_t ent_hi;

   logic     tlb_miss;
   logic     perm_denied;
   logic     exc_itm;
   logic     exc_ipf;
   ppn_t     ppn_sel;
   logic     page_unc;
   logic     seg_unc;

   // Capture vpn and status alongside the array read
   // Later PSR writes leave an issued request alone
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         vpn_q    <= '0;
         psr_q    <= '0;
         req_seen <= 1'b0;
      end
      else if (re)
      begin
         vpn_q    <= vpn;
         psr_q    <= psr;
         req_seen <= 1'b1;
      end
   end

   // Response strobe
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= re;
   end

   assign ent_lo = itlb_lo_t'(tlb_lo);
   assign ent_hi = itlb_hi_t'(tlb_hi);

   // Miss on invalid entry or tag mismatch
   assign tlb_miss = ~ent_lo.valid | (ent_lo.vpn != vpn_q);

   // rx governs root mode, ux user mode
   assign perm_denied = psr_q.rm ? ~ent_hi.rx : ~ent_hi.ux;

   // Exceptions only when translating
   assign exc_itm = psr_q.imme & tlb_miss;
   // Page fault never alongside a miss
   assign exc_ipf = psr_q.imme & ~tlb_miss & perm_denied;

   // Identity mapping with translation off
   assign ppn_sel = psr_q.imme ? ent_hi.ppn : vpn_q;

   // Entry attribute only counts on a clean hit
   assign page_unc = psr_q.imme & ~tlb_miss & ~perm_denied & ent_hi.unc;

   // Low half of physical space is uncached
   assign seg_unc = UNC_SEG & req_seen & ~exc_itm & ~exc_ipf & ~ppn_sel[PPN_W-1];

   assign rsp.ppn      = ppn_sel;
   assign rsp.eitm     = exc_itm;
   assign rsp.eipf     = exc_ipf;
   assign rsp.uncached = page_unc | seg_unc;

endmodule

/* rtl/immu_defs.svh */
`ifndef IMMU_DEFS_SVH
`define IMMU_DEFS_SVH

// Virtual and physical address width
`define IMMU_AW 32

// Width of MSR data and of each TLB entry word
`define IMMU_DW 32

// log2 of page size, 8 KiB pages
`define IMMU_P_PAGE 13

// log2 of ITLB set count, 16 sets
// Must stay within the VPN width
`define IMMU_P_SETS 4

// MSR address width
`define IMMU_MSR_AW 12

// Processor status register
`define MSR_PSR 12'h000

// IMMU identification word
`define MSR_IMMID 12'h004

// TLB entry windows, low IMMU_P_SETS bits pick the set
`define MSR_ITLBL_BASE 12'h200
`define MSR_ITLBH_BASE 12'h300

// Physical pages below the top half are uncached when set
`define IMMU_UNC_SEG 1

`endif

/* rtl/immu_msr.sv */
`timescale 1ns/1ps

`include "immu_defs.svh"

module immu_msr (
   input  logic                clk,
   input  logic                rst_n,
   // Write side
   input  logic                msr_we,
   input  immu_pkg::msr_wr_t   msr_wr,
   // Read side
   input  logic                msr_re,
   input  immu_pkg::msr_addr_t msr_raddr,
   output immu_pkg::word_t     msr_rdata,
   output logic                msr_rvalid,
   // Status to the translation block
   output immu_pkg::psr_t      psr,
   // TLB array write ports
   output logic                lo_we,
   output logic                hi_we,
   output immu_pkg::tlb_idx_t  lo_idx,
   output immu_pkg::tlb_idx_t  hi_idx,
   output immu_pkg::word_t     lo_data,
   output immu_pkg::word_t     hi_data
);

   import immu_pkg::*;

   localparam int AW = `IMMU_MSR_AW;
   localparam int IW = `IMMU_P_SETS;

   localparam msr_addr_t PSR_ADDR   = `MSR_PSR;
   localparam msr_addr_t IMMID_ADDR = `MSR_IMMID;
   localparam msr_addr_t LO_BASE    = `MSR_ITLBL_BASE;
   localparam msr_addr_t HI_BASE    = `MSR_ITLBH_BASE;

   // IMMID reports the set-count exponent
   localparam word_t IMMID_VAL = `IMMU_P_SETS;

   logic  psr_hit;
   logic  lo_hit;
   logic  hi_hit;
   word_t rd_next;

   // Write decode
   assign psr_hit = (msr_wr.addr == PSR_ADDR);
   // TLB windows match on the bits above the index
   assign lo_hit  = (msr_wr.addr[AW-1:IW] == LO_BASE[AW-1:IW]);
   assign hi_hit  = (msr_wr.addr[AW-1:IW] == HI_BASE[AW-1:IW]);

   // Entry writes go straight to the arrays this cycle
   assign lo_we   = msr_we & lo_hit;
   assign hi_we   = msr_we & hi_hit;
   assign lo_idx  = msr_wr.addr[IW-1:0];
   assign hi_idx  = msr_wr.addr[IW-1:0];
   assign lo_data = msr_wr.data;
   assign hi_data = msr_wr.data;

   // PSR, translation off and user mode out of reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         psr <= '0;
      else if (msr_we && psr_hit)
         psr <= msr_wr.data[$bits(psr_t)-1:0];
   end

   // Read mux
   always_comb
   begin
      rd_next = '0;
      case (msr_raddr)
         PSR_ADDR:
         begin
            // Zero-extended status bits
            rd_next[$bits(psr_t)-1:0] = psr;
         end
         IMMID_ADDR:
         begin
            rd_next = IMMID_VAL;
         end
         default:
         begin
            // Unmapped and write-only addresses read zero
            rd_next = '0;
         end
      endcase
   end

   // Read strobe, one cycle after the request
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         msr_rvalid <= 1'b0;
      else
         msr_rvalid <= msr_re;
   end

   // Read data, captured with the request
   always_ff @(posedge clk)
   begin
      if (msr_re)
         msr_rdata <= rd_next;
   end

endmodule

/* rtl/immu_pkg.sv */
`include "immu_defs.svh"

package immu_pkg;

   // Page numbers, address minus page offset
   typedef logic [`IMMU_AW-`IMMU_P_PAGE-1:0] vpn_t;
   typedef logic [`IMMU_AW-`IMMU_P_PAGE-1:0] ppn_t;

   // ITLB set index
   typedef logic [`IMMU_P_SETS-1:0] tlb_idx_t;

   // MSR address and data
   typedef logic [`IMMU_MSR_AW-1:0] msr_addr_t;
   typedef logic [`IMMU_DW-1:0]     word_t;

   // Lower entry word, tag and valid
   typedef struct packed {
      vpn_t        vpn;
      logic [11:0] rsvd;
      logic        valid;
   } itlb_lo_t;

   // Higher entry word, translation and attributes
   // Bit 8 (shared) and bit 0 (present) sit in the reserved fields
   typedef struct packed {
      ppn_t        ppn;
      logic [4:0]  rsvd_a;
      logic        unc;
      logic [1:0]  rsvd_b;
      logic        rx;
      logic        ux;
      logic [2:0]  rsvd_c;
   } itlb_hi_t;

   // PSR bits 1 and 0
   typedef struct packed {
      logic imme;
      logic rm;
   } psr_t;

   // One MSR write beat
   typedef struct packed {
      msr_addr_t addr;
      word_t     data;
   } msr_wr_t;

   // Translation result toward fetch
   typedef struct packed {
      ppn_t ppn;
      logic eitm;
      logic eipf;
      logic uncached;
   } immu_rsp_t;

endpackage

/* rtl/immu_top.sv */
`timescale 1ns/1ps

`include "immu_defs.svh"

module immu_top (
   input  logic                clk,
   input  logic                rst_n,
   // Translation request and response
   input  logic                re,
   input  immu_pkg::vpn_t      vpn,
   output immu_pkg::immu_rsp_t rsp,
   output logic                rsp_valid,
   // MSR bus
   input  logic                msr_we,
   input  immu_pkg::msr_wr_t   msr_wr,
   input  logic                msr_re,
   input  immu_pkg::msr_addr_t msr_raddr,
   output immu_pkg::word_t     msr_rdata,
   output logic                msr_rvalid
);

   import immu_pkg::*;

   psr_t     psr;
   logic     lo_we;
   logic     hi_we;
   tlb_idx_t lo_idx;
   tlb_idx_t hi_idx;
   word_t    lo_data;
   word_t    hi_data;
   word_t    tlb_lo;
   word_t    tlb_hi;
   tlb_idx_t rd_idx;

   // Direct mapped, set picked by low vpn bits
   assign rd_idx = vpn[`IMMU_P_SETS-1:0];

   // MSR front end
   immu_msr u_msr (
      .clk        (clk),
      .rst_n      (rst_n),
      .msr_we     (msr_we),
      .msr_wr     (msr_wr),
      .msr_re     (msr_re),
      .msr_raddr  (msr_raddr),
      .msr_rdata  (msr_rdata),
      .msr_rvalid (msr_rvalid),
      .psr        (psr),
      .lo_we      (lo_we),
      .hi_we      (hi_we),
      .lo_idx     (lo_idx),
      .hi_idx     (hi_idx),
      .lo_data    (lo_data),
      .hi_data    (hi_data)
   );

   // Tag and valid words
   itlb_ram u_tlb_lo (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (rd_idx),
      .rdata (tlb_lo),
      .we    (lo_we),
      .waddr (lo_idx),
      .wdata (lo_data)
   );

   // PPN and attribute words
   itlb_ram u_tlb_hi (
      .clk   (clk),
      .rst_n (rst_n),
      .re    (re),
      .raddr (rd_idx),
      .rdata (tlb_hi),
      .we    (hi_we),
      .waddr (hi_idx),
      .wdata (hi_data)
   );

   // Translation and checks
   immu u_immu (
      .clk       (clk),
      .rst_n     (rst_n),
      .re        (re),
      .vpn       (vpn),
      .psr       (psr),
      .tlb_lo    (tlb_lo),
      .tlb_hi    (tlb_hi),
      .rsp       (rsp),
      .rsp_valid (rsp_valid)
   );

endmodule

/* rtl/itlb_ram.sv */
`timescale 1ns/1ps

`include "immu_defs.svh"

module itlb_ram (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               re,
   input  immu_pkg::tlb_idx_t raddr,
   output immu_pkg::word_t    rdata,
   input  logic               we,
   input  immu_pkg::tlb_idx_t waddr,
   input  immu_pkg::word_t    wdata
);

   import immu_pkg::*;

   localparam int SETS = 1 << `IMMU_P_SETS;

   // One word per set
   word_t mem [SETS];

   // Contents clear on reset so every entry starts invalid
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < SETS; i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read, old data on a same-cycle write
   // Holds between reads
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rdata <= '0;
      else if (re)
         rdata <= mem[raddr];
   end

endmodule

/* tb/immu_top_assert.sv */
`timescale 1ns/1ps

`include "immu_defs.svh"

module immu_top_assert (
   input logic                clk,
   input logic                rst_n,
   input logic                re,
   input logic                rsp_valid,
   input immu_pkg::immu_rsp_t rsp
);

   import immu_pkg::*;

   // Set index is carved out of the vpn
   if (`IMMU_P_SETS > $bits(vpn_t))
   begin : g_sets_check
      $error("ITLB set index is wider than the VPN");
   end

   // A miss is never also a page fault
   a_exc_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(rsp.eitm && rsp.eipf))
      else $error("eitm and eipf raised together");

   // Response one cycle after each request, and only then
   a_rsp_after_re: assert property (@(posedge clk) disable iff (!rst_n) re |=> rsp_valid)
      else $error("rsp_valid missing one cycle after re");
   a_no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_n) !re |=> !rsp_valid)
      else $error("rsp_valid without a request");

endmodule

bind immu immu_top_assert u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .re        (re),
   .rsp_valid (rsp_valid),
   .rsp       (rsp)
);

/* tb/immu_top_tb.sv */
`timescale 1ns/1ps

`include "immu_defs.svh"

module immu_top_tb;

   import immu_pkg::*;

   localparam int        MAX_CYCLES = 2000;
   localparam int        SETS       = 1 << `IMMU_P_SETS;
   localparam int        VPN_W      = `IMMU_AW - `IMMU_P_PAGE;
   localparam msr_addr_t PSR_A      = `MSR_PSR;
   localparam msr_addr_t IMMID_A    = `MSR_IMMID;
   localparam msr_addr_t LO_BASE    = `MSR_ITLBL_BASE;
   localparam msr_addr_t HI_BASE    = `MSR_ITLBH_BASE;

   // Expected response with the cycle its request went out
   typedef struct packed {
      int        stamp;
      immu_rsp_t rsp;
   } rsp_exp_t;

   // Expected read data with the cycle its read went out
   typedef struct packed {
      int    stamp;
      word_t data;
   } rd_exp_t;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       re;
   vpn_t       vpn;
   immu_rsp_t  rsp;
   logic       rsp_valid;
   logic       msr_we;
   msr_wr_t    msr_wr;
   logic       msr_re;
   msr_addr_t  msr_raddr;
   word_t      msr_rdata;
   logic       msr_rvalid;
   // Shadow of the software-visible state
   word_t      sh_lo [SETS];
   word_t      sh_hi [SETS];
   logic [1:0] sh_psr;
   rsp_exp_t   rsp_q [$];
   rd_exp_t    rd_q [$];
   int         cyc = 0;
   int         value_errors = 0;
   int         proto_errors = 0;
   integer     seed = 43;

   immu_top dut (.*);

   always #10 clk = ~clk;

   // Cycle count and run limit
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles with the test still running", cyc);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // Expected translation, entry fields taken by bit position
   function automatic immu_rsp_t expect_translation(vpn_t v, word_t lo, word_t hi,
                                                    logic [1:0] st);
      immu_rsp_t r;
      logic      miss;
      logic      deny;
      miss = !lo[0] || (lo[`IMMU_AW-1:`IMMU_P_PAGE] != v);
      // st[0] is root mode, rx bit 4 and ux bit 3
      deny = st[0] ? !hi[4] : !hi[3];
      r.ppn = st[1] ? hi[`IMMU_AW-1:`IMMU_P_PAGE] : v;
      r.eitm = st[1] && miss;
      r.eipf = st[1] && !miss && deny;
      r.uncached = st[1] && !miss && !deny && hi[7];
      // Low half of physical space
      if ((`IMMU_UNC_SEG != 0) && !r.eitm && !r.eipf && !r.ppn[VPN_W-1])
         r.uncached = 1'b1;
      return r;
   endfunction

   function automatic word_t expect_read(msr_addr_t a, logic [1:0] st);
      if (a == PSR_A)
         return {30'b0, st};
      if (a == IMMID_A)
         return `IMMU_P_SETS;
      return '0;
   endfunction

   function automatic word_t make_hi(ppn_t p, logic unc, logic rx, logic ux);
      word_t w;
      w = '0;
      w[`IMMU_AW-1:`IMMU_P_PAGE] = p;
      w[7] = unc;
      w[4] = rx;
      w[3] = ux;
      return w;
   endfunction

   function automatic vpn_t rand_vpn();
      word_t r;
      r = $random(seed);
      return r[VPN_W-1:0];
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         value_errors++;
      end
   endtask

   // One cycle of stimulus, model sees state from before the edge
   task automatic drive_cycle(input logic do_req, input vpn_t v, input logic do_wr,
                              input msr_addr_t wa, input word_t wd,
                              input logic do_rd, input msr_addr_t ra);
      rsp_exp_t e;
      rd_exp_t  d;
      tlb_idx_t ix;
      @(negedge clk);
      re = do_req;
      vpn = v;
      msr_we = do_wr;
      msr_wr = {wa, wd};
      msr_re = do_rd;
      msr_raddr = ra;
      ix = v[`IMMU_P_SETS-1:0];
      if (do_req)
      begin
         e.stamp = cyc;
         e.rsp = expect_translation(v, sh_lo[ix], sh_hi[ix], sh_psr);
         rsp_q.push_back(e);
      end
      if (do_rd)
      begin
         d.stamp = cyc;
         d.data = expect_read(ra, sh_psr);
         rd_q.push_back(d);
      end
      if (do_wr && wa == PSR_A)
         sh_psr = wd[1:0];
      else if (do_wr && wa[11:`IMMU_P_SETS] == LO_BASE[11:`IMMU_P_SETS])
         sh_lo[wa[`IMMU_P_SETS-1:0]] = wd;
      else if (do_wr && wa[11:`IMMU_P_SETS] == HI_BASE[11:`IMMU_P_SETS])
         sh_hi[wa[`IMMU_P_SETS-1:0]] = wd;
   endtask

   task automatic request(input vpn_t v);
      drive_cycle(1'b1, v, 1'b0, '0, '0, 1'b0, '0);
   endtask

   task automatic msr_write(input msr_addr_t a, input word_t d);
      drive_cycle(1'b0, '0, 1'b1, a, d, 1'b0, '0);
   endtask

   task automatic msr_read(input msr_addr_t a);
      drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1, a);
   endtask

   // Valid tag word then translation word for the set of v
   task automatic write_entry(input vpn_t v, input word_t hi);
      msr_write({LO_BASE[11:`IMMU_P_SETS], v[`IMMU_P_SETS-1:0]}, {v, 13'b0} | 32'h1);
      msr_write({HI_BASE[11:`IMMU_P_SETS], v[`IMMU_P_SETS-1:0]}, hi);
   endtask

   // Compare responses and read data as they come out
   always @(negedge clk)
   begin : compare
      rsp_exp_t e;
      rd_exp_t  d;
      if (rst_n && rsp_valid && rsp_q.size() == 0)
      begin
         $display("Response valid at %0t with no request outstanding", $time);
         proto_errors++;
      end
      else if (rst_n && rsp_valid)
      begin
         e = rsp_q.pop_front();
         check_val("rsp.ppn", 32'(rsp.ppn), 32'(e.rsp.ppn));
         check_val("rsp.eitm", 32'(rsp.eitm), 32'(e.rsp.eitm));
         check_val("rsp.eipf", 32'(rsp.eipf), 32'(e.rsp.eipf));
         check_val("rsp.uncached", 32'(rsp.uncached), 32'(e.rsp.uncached));
      end
      else if (rst_n && rsp_q.size() != 0 && rsp_q[0].stamp + 1 <= cyc)
      begin
         $display("Response for the request of cycle %0d never came", rsp_q[0].stamp);
         proto_errors++;
         e = rsp_q.pop_front();
      end
      if (rst_n && msr_rvalid && rd_q.size() == 0)
      begin
         $display("MSR read data valid at %0t with no read outstanding", $time);
         proto_errors++;
      end
      else if (rst_n && msr_rvalid)
      begin
         d = rd_q.pop_front();
         check_val("msr_rdata", msr_rdata, d.data);
      end
      else if (rst_n && rd_q.size() != 0 && rd_q[0].stamp + 1 <= cyc)
      begin
         $display("MSR read data for the read of cycle %0d never came", rd_q[0].stamp);
         proto_errors++;
         d = rd_q.pop_front();
      end
   end

   initial
   begin
      vpn_t  va;
      vpn_t  vb;
      vpn_t  pool [8];
      word_t r;
      rst_n = 1'b0;
      re = 1'b0;
      vpn = '0;
      msr_we = 1'b0;
      msr_wr = '0;
      msr_re = 1'b0;
      msr_raddr = '0;
      sh_psr = 2'b00;
      for (int i = 0; i < SETS; i++)
      begin
         sh_lo[i] = '0;
         sh_hi[i] = '0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Outputs idle and response cleared out of reset
      check_val("rsp", 32'(rsp), 32'h0);
      check_val("rsp_valid", 32'(rsp_valid), 32'h0);
      check_val("msr_rvalid", 32'(msr_rvalid), 32'h0);

      // Reset values and identity mapping
      msr_read(PSR_A);
      msr_read(IMMID_A);
      request(19'h40123);
      request(19'h00456);
      repeat (4) request(rand_vpn());

      // Translation on, empty TLB misses
      msr_write(PSR_A, 32'h2);
      msr_read(PSR_A);
      repeat (8) request(rand_vpn());

      // Hits on programmed sets, then an alias with another tag
      for (int i = 0; i < 4; i++)
      begin
         va = rand_vpn();
         va[3:0] = 4'(i);
         pool[i] = va;
         write_entry(va, make_hi(rand_vpn(), va[5], 1'b1, 1'b1));
      end
      for (int i = 0; i < 8; i++)
         request(pool[i % 4]);
      request(pool[2] ^ 19'h00400);

      // Permission per mode, PSR write in the same cycle as a request
      va = {rand_vpn() & 19'h7fff0} | 19'h5;
      vb = {rand_vpn() & 19'h7fff0} | 19'h6;
      write_entry(va, make_hi(rand_vpn(), 1'b0, 1'b1, 1'b0));
      write_entry(vb, make_hi(rand_vpn(), 1'b1, 1'b0, 1'b1));
      request(va);
      request(vb);
      drive_cycle(1'b1, va, 1'b1, PSR_A, 32'h3, 1'b1, PSR_A);
      request(va);
      request(vb);
      msr_read(PSR_A);

      // Random mix over sets 8 to 11, two tags per set
      for (int j = 0; j < 8; j++)
      begin
         pool[j] = rand_vpn();
         pool[j][3:0] = 4'(8 + j / 2);
         pool[j][VPN_W-1] = j[0];
         write_entry(pool[j], $random(seed));
      end
      repeat (200)
      begin
         r = $random(seed);
         va = pool[r[4:2]];
         vb = pool[r[11:9]];
         case (r[8:7])
            2'd0: drive_cycle(r[1:0] != 0, va, r[6:5] == 0,
                              {LO_BASE[11:4], vb[3:0]}, {vb, 12'b0, r[12] | r[13]},
                              r[19:17] == 0, r[31:20]);
            2'd3: drive_cycle(r[1:0] != 0, va, r[6:5] == 0, PSR_A, {30'b0, r[14] | r[16], r[15]},
                              r[19:17] == 0, r[20] ? PSR_A : IMMID_A);
            default: drive_cycle(r[1:0] != 0, va, r[6:5] == 0,
                                 {HI_BASE[11:4], vb[3:0]}, $random(seed),
                                 r[19:17] == 0, r[21] ? PSR_A : r[31:20]);
         endcase
      end

      drive_cycle(1'b0, '0, 1'b0, '0, '0, 1'b0, '0);
      while (rsp_q.size() != 0 || rd_q.size() != 0)
         @(negedge clk);
      repeat (2) @(negedge clk);
      $display("Run complete: %0d value errors, %0d protocol errors", value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
